/* adc_ads816x_model.sv */
`timescale 1ns/100ps

module adc_ads816x_model (
  input  logic clk,
  input  logic resetn,
  input  logic n_cs,
  input  logic mosi,
  output logic miso
);

  import adc_ctrl_pkg::*;

  logic [FRAME_BITS-1:0] req_sr;    // Incoming request, MSB first
  logic [SAMPLE_W-1:0]   reply_sr;  // Reply to the previous request
  logic [BIT_CNT_W-1:0]  bit_idx;   // Bits of the current frame seen so far
  logic [12:0]           req_count; // Requests since reset, modulo 8192
  logic [CH_W-1:0]       req_ch;

  // Channel sits right under the two-bit prefix, last bit comes straight from mosi
  assign req_ch = req_sr[FRAME_BITS-4 -: CH_W];
  assign miso   = reply_sr[SAMPLE_W-1];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      req_sr    <= '0;
      reply_sr  <= '0;  // Nothing pending before the first frame
      bit_idx   <= '0;
      req_count <= '0;
    end else if (!n_cs) begin
      req_sr <= {req_sr[FRAME_BITS-2:0], mosi};
      if (bit_idx == BIT_CNT_W'(FRAME_BITS - 1)) begin
        // Frame complete, its answer goes out during the next frame
        reply_sr  <= {req_ch, req_count};
        req_count <= req_count + 1'b1;
        bit_idx   <= '0;
      end else begin
        reply_sr <= {reply_sr[SAMPLE_W-2:0], 1'b0};  // Next bit after the edge
        bit_idx  <= bit_idx + 1'b1;
      end
    end
  end

endmodule

/* adc_cmd_sequencer.sv */
`timescale 1ns/100ps

module adc_cmd_sequencer (
  input  logic                             clk,
  input  logic                             resetn,
  output logic                             cmd_buf_rd_en,
  input  logic [adc_ctrl_pkg::CMD_W-1:0]   cmd_buf_word,
  input  logic                             cmd_buf_empty,
  output logic                             frame_start,
  output logic [adc_ctrl_pkg::CH_W-1:0]    frame_ch,
  output adc_ctrl_pkg::frame_kind_e        frame_kind,
  input  logic                             frame_done,
  input  logic                             write_dropped,
  output logic                             halt,
  output logic                             bad_cmd,
  output logic                             cmd_buf_underflow,
  output logic                             data_buf_overflow,
  output logic                             delay_too_short
);

  import adc_ctrl_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_DELAY, S_READ, S_HALT} state_e;

  state_e                 state;
  logic [CH_W-1:0]        sample_order [N_CH];
  logic [DELAY_W-1:0]     delay_timer;
  logic [FRAME_IDX_W-1:0] frame_idx;   // Frame now on the wire
  logic                   single_rd;   // Current read is single-channel
  logic                   timed_rd;    // Current read checks the delay
  logic                   frames_done; // Last frame of the read has finished
  logic                   expect_next; // CONT bit of the running command

  logic [OP_W-1:0]        opcode;
  logic                   cmd_done, do_next, at_last, last_done, start_rd, issue;
  logic                   err_bad, err_underflow, err_short, any_err;
  logic [FRAME_IDX_W-1:0] nxt_idx;
  logic                   nxt_single;

  ////////////////////
  // Command finish and fetch

  assign opcode    = cmd_buf_word[OPCODE_HI:OPCODE_LO];
  assign at_last   = single_rd ? (frame_idx == 1) : (frame_idx == FRAME_IDX_W'(N_CH));
  assign last_done = frames_done || (frame_done && at_last);

  always_comb begin
    case (state)
      S_IDLE:  cmd_done = 1'b1;
      S_DELAY: cmd_done = (delay_timer == 0);
      S_READ:  cmd_done = last_done && (delay_timer == 0); // Frames out and delay expired
      default: cmd_done = 1'b0;                            // Halted
    endcase
  end

  assign do_next       = cmd_done && !cmd_buf_empty;
  assign cmd_buf_rd_en = do_next; // Pop in the finishing cycle
  assign start_rd      = do_next && (opcode == OP_ADC_RD || opcode == OP_ADC_RD_CH);

  // Error sources
  assign err_bad       = do_next && (opcode > OP_ADC_RD_CH);
  assign err_underflow = cmd_done && cmd_buf_empty && expect_next;
  assign err_short     = (state == S_READ) && timed_rd && (delay_timer == 0) && !last_done;
  assign any_err       = err_bad || err_underflow || err_short || write_dropped;
  assign halt          = (state == S_HALT);

  ////////////////////
  // Frame scheduling

  // Next frame index and read type
  assign issue      = !any_err && (start_rd || (state == S_READ && frame_done && !at_last));
  assign nxt_idx    = start_rd ? '0 : frame_idx + 1'b1;
  assign nxt_single = start_rd ? (opcode == OP_ADC_RD_CH) : single_rd;

  always_comb begin
    frame_ch   = '0;      // Dummy frames request channel 0
    frame_kind = FK_NONE;
    if (nxt_single) begin
      if (nxt_idx == 0) begin
        frame_ch   = cmd_buf_word[CH_W-1:0]; // First frame only starts with the fetch
        frame_kind = FK_SINGLE;
      end
    end else if (nxt_idx < FRAME_IDX_W'(N_CH)) begin
      frame_ch   = sample_order[nxt_idx[CH_W-1:0]];
      frame_kind = nxt_idx[0] ? FK_PAIR_SECOND : FK_PAIR_FIRST; // Even frames open a pair
    end
  end

  assign frame_start = issue;

  ////////////////////
  // State, timer, flags

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state             <= S_IDLE;
      delay_timer       <= '0;
      frame_idx         <= '0;
      single_rd         <= 1'b0;
      timed_rd          <= 1'b0;
      frames_done       <= 1'b0;
      expect_next       <= 1'b0;
      bad_cmd           <= 1'b0;
      cmd_buf_underflow <= 1'b0;
      data_buf_overflow <= 1'b0;
      delay_too_short   <= 1'b0;
    end else if (any_err) begin
      state             <= S_HALT; // Sticky until reset
      bad_cmd           <= bad_cmd | err_bad;
      cmd_buf_underflow <= cmd_buf_underflow | err_underflow;
      data_buf_overflow <= data_buf_overflow | write_dropped;
      delay_too_short   <= delay_too_short | err_short;
    end else if (state != S_HALT) begin
      if (delay_timer != 0) delay_timer <= delay_timer - 1'b1;
      if (issue && !start_rd) frame_idx <= nxt_idx;                   // Step through the read
      if (state == S_READ && frame_done && at_last) frames_done <= 1'b1;
      if (cmd_done) begin
        if (cmd_buf_empty) begin
          state       <= S_IDLE;
          expect_next <= 1'b0;
        end else begin
          expect_next <= cmd_buf_word[CONT_BIT] && (opcode != OP_SET_ORD);
          case (opcode)
            OP_NO_OP: begin
              state       <= S_DELAY;
              delay_timer <= cmd_buf_word[DELAY_W-1:0];
            end
            OP_SET_ORD: state <= S_IDLE; // Table loads below
            OP_ADC_RD, OP_ADC_RD_CH: begin
              state       <= S_READ;
              frame_idx   <= '0;
              frames_done <= 1'b0;
              single_rd   <= (opcode == OP_ADC_RD_CH);
              timed_rd    <= (opcode == OP_ADC_RD);
              // Single read has no delay field since the channel sits in the low bits
              delay_timer <= (opcode == OP_ADC_RD) ? cmd_buf_word[DELAY_W-1:0] : '0;
            end
            default: state <= S_HALT; // Caught by err_bad
          endcase
        end
      end
    end
  end

  // Sample order table is identity after reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < N_CH; i++) sample_order[i] <= CH_W'(i);
    end else if (do_next && opcode == OP_SET_ORD) begin
      for (int i = 0; i < N_CH; i++) sample_order[i] <= cmd_buf_word[i*CH_W +: CH_W];
    end
  end

endmodule

/* adc_ctrl.f */
adc_ctrl_pkg.sv
adc_cmd_sequencer.sv
spi_frame_tx.sv
spi_frame_rx.sv
sample_packer.sv
adc_ctrl_top.sv
adc_ads816x_model.sv
adc_ctrl_assert.sv
tb_adc_ctrl.sv

/* adc_ctrl_assert.sv */
`timescale 1ns/100ps

module adc_ctrl_assert (
  input logic clk,
  input logic resetn,
  input logic n_cs,
  input logic data_buf_wr_en,
  input logic data_buf_full,
  input logic bad_cmd,
  input logic cmd_buf_underflow,
  input logic data_buf_overflow,
  input logic delay_too_short
);

  import adc_ctrl_pkg::*;

  logic       err_any;
  logic [5:0] low_cnt;  // Consecutive cycles with n_cs low

  assign err_any = bad_cmd | cmd_buf_underflow | data_buf_overflow | delay_too_short;

  always_ff @(posedge clk) begin
    if (!resetn || n_cs) low_cnt <= '0;
    else                 low_cnt <= low_cnt + 1'b1;
  end

  ////////////////////
  // Frame length

  a_frame_not_long: assert property (@(posedge clk) disable iff (!resetn)
    !n_cs |-> low_cnt < 6'(FRAME_BITS))
    else $error("n_cs low longer than one frame");

  a_frame_not_short: assert property (@(posedge clk) disable iff (!resetn)
    $rose(n_cs) |-> (low_cnt == 6'(FRAME_BITS)) || err_any)  // Halt may cut a frame
    else $error("n_cs low shorter than one frame");

  ////////////////////
  // Data buffer and halt

  a_no_write_when_full: assert property (@(posedge clk) disable iff (!resetn)
    $past(data_buf_full) |-> !data_buf_wr_en)
    else $error("data buffer written while full");

  a_cs_high_on_error: assert property (@(posedge clk) disable iff (!resetn)
    err_any |-> n_cs)
    else $error("n_cs low while an error flag is set");

endmodule

bind adc_ctrl_top adc_ctrl_assert u_assert (
  .clk(clk), .resetn(resetn), .n_cs(n_cs),
  .data_buf_wr_en(data_buf_wr_en), .data_buf_full(data_buf_full),
  .bad_cmd(bad_cmd), .cmd_buf_underflow(cmd_buf_underflow),
  .data_buf_overflow(data_buf_overflow), .delay_too_short(delay_too_short)
);

/* adc_ctrl_pkg.sv */
package adc_ctrl_pkg;

  ////////////////////
  // Command word

  localparam int CMD_W     = 32;  // Command and data word width
  localparam int OPCODE_HI = 31;
  localparam int OPCODE_LO = 29;
  localparam int OP_W      = OPCODE_HI - OPCODE_LO + 1;
  localparam int CONT_BIT  = 27;  // Next command must be waiting at finish
  localparam int DELAY_W   = 25;  // Delay field, bits 24..0, in clk cycles
  localparam int CH_W      = 3;   // Channel field, single read uses bits 2..0
  localparam int N_CH      = 8;

  // Opcodes
  localparam logic [OP_W-1:0] OP_NO_OP     = 3'd0;
  localparam logic [OP_W-1:0] OP_SET_ORD   = 3'd1;
  localparam logic [OP_W-1:0] OP_ADC_RD    = 3'd2;
  localparam logic [OP_W-1:0] OP_ADC_RD_CH = 3'd3;

  ////////////////////
  // SPI frame

  localparam int FRAME_BITS     = 16;
  localparam logic [1:0] OTF_REQ_PREFIX = 2'd2;  // On-the-fly sample request
  localparam int OTF_PAD_W      = FRAME_BITS - 2 - CH_W;  // Zero tail after channel
  localparam int CS_HIGH_CYCLES = 8;  // n_cs high time before each frame
  localparam int SAMPLE_W       = 16;

  // Counter widths
  localparam int BIT_CNT_W   = 5;
  localparam int CS_CNT_W    = 4;
  localparam int FRAME_IDX_W = 4;

  // What the reply to a frame's request means
  typedef enum logic [1:0] {
    FK_NONE        = 2'd0,  // Dummy request, reply discarded
    FK_PAIR_FIRST  = 2'd1,  // Lower half of a pair word
    FK_PAIR_SECOND = 2'd2,  // Upper half, completes the word
    FK_SINGLE      = 2'd3   // Zero-extended single sample
  } frame_kind_e;

endpackage

/* adc_ctrl_top.sv */
`timescale 1ns/100ps

module adc_ctrl_top (
  input  logic                           clk,
  input  logic                           resetn,
  // Command buffer, first-word-fall-through
  output logic                           cmd_buf_rd_en,
  input  logic [adc_ctrl_pkg::CMD_W-1:0] cmd_buf_word,
  input  logic                           cmd_buf_empty,
  // Data buffer
  output logic                           data_buf_wr_en,
  output logic [adc_ctrl_pkg::CMD_W-1:0] data_word,
  input  logic                           data_buf_full,
  // Sticky errors
  output logic                           bad_cmd,
  output logic                           cmd_buf_underflow,
  output logic                           data_buf_overflow,
  output logic                           delay_too_short,
  // ADC SPI
  output logic                           n_cs,
  output logic                           mosi,
  input  logic                           miso
);

  import adc_ctrl_pkg::*;

  logic                frame_start, frame_done, halt, write_dropped;
  logic [CH_W-1:0]     frame_ch;
  frame_kind_e         frame_kind, tx_kind, sample_kind;
  logic                tx_frame_start, tx_frame_done, sample_valid;
  logic [SAMPLE_W-1:0] sample;

  adc_cmd_sequencer u_seq (
    .clk(clk), .resetn(resetn),
    .cmd_buf_rd_en(cmd_buf_rd_en), .cmd_buf_word(cmd_buf_word), .cmd_buf_empty(cmd_buf_empty),
    .frame_start(frame_start), .frame_ch(frame_ch), .frame_kind(frame_kind),
    .frame_done(frame_done), .write_dropped(write_dropped), .halt(halt),
    .bad_cmd(bad_cmd), .cmd_buf_underflow(cmd_buf_underflow),
    .data_buf_overflow(data_buf_overflow), .delay_too_short(delay_too_short)
  );

  spi_frame_tx u_tx (
    .clk(clk), .resetn(resetn), .halt(halt),
    .frame_start(frame_start), .frame_ch(frame_ch), .frame_kind(frame_kind),
    .n_cs(n_cs), .mosi(mosi), .frame_done(frame_done),
    .tx_frame_start(tx_frame_start), .tx_frame_done(tx_frame_done), .tx_kind(tx_kind)
  );

  spi_frame_rx u_rx (
    .clk(clk), .resetn(resetn), .halt(halt), .miso(miso),
    .tx_frame_start(tx_frame_start), .tx_frame_done(tx_frame_done), .tx_kind(tx_kind),
    .sample_valid(sample_valid), .sample(sample), .sample_kind(sample_kind)
  );

  sample_packer u_pack (
    .clk(clk), .resetn(resetn), .halt(halt),
    .sample_valid(sample_valid), .sample(sample), .sample_kind(sample_kind),
    .data_buf_full(data_buf_full), .data_buf_wr_en(data_buf_wr_en),
    .data_word(data_word), .write_dropped(write_dropped)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ADC controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_adc_ctrl \
  -f adc_ctrl.f \
  --Mdir obj_dir -o sim_adc_ctrl > build.log 2>&1 \
  && ./obj_dir/sim_adc_ctrl > sim.log 2>&1 \
  || echo "Build or simulation ended with an error status"

[ -f sim.log ] && cat sim.log

grep -q "RESULT: PASS" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

/* sample_packer.sv */
`timescale 1ns/100ps

module sample_packer (
  input  logic                              clk,
  input  logic                              resetn,
  input  logic                              halt,
  input  logic                              sample_valid,
  input  logic [adc_ctrl_pkg::SAMPLE_W-1:0] sample,
  input  adc_ctrl_pkg::frame_kind_e         sample_kind,
  input  logic                              data_buf_full,
  output logic                              data_buf_wr_en,
  output logic [adc_ctrl_pkg::CMD_W-1:0]    data_word,
  output logic                              write_dropped
);

  import adc_ctrl_pkg::*;

  logic [SAMPLE_W-1:0] first_q;  // Held lower half of a pair
  logic [CMD_W-1:0]    word_nxt;
  logic                word_rdy; // A complete word this cycle

  ////////////////////
  // Word assembly

  always_comb begin
    word_rdy = 1'b0;
    word_nxt = {{(CMD_W-SAMPLE_W){1'b0}}, sample}; // Zero-extended by default
    case (sample_kind)
      FK_PAIR_SECOND: begin
        word_rdy = sample_valid;
        word_nxt = {sample, first_q}; // Second sample on top
      end
      FK_SINGLE: word_rdy = sample_valid;
      default: word_rdy = 1'b0;       // First of a pair or nothing
    endcase
  end

  always_ff @(posedge clk) begin
    if (sample_valid && sample_kind == FK_PAIR_FIRST) first_q <= sample;
  end

  ////////////////////
  // Data buffer write

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      data_buf_wr_en <= 1'b0;
      write_dropped  <= 1'b0;
    end else begin
      data_buf_wr_en <= word_rdy && !data_buf_full;
      write_dropped  <= word_rdy && data_buf_full; // Word lost, sequencer halts
    end
  end

  always_ff @(posedge clk) begin
    if (word_rdy && !data_buf_full) data_word <= word_nxt;
  end

endmodule

/* spi_frame_rx.sv */
`timescale 1ns/100ps

module spi_frame_rx (
  input  logic                              clk,
  input  logic                              resetn,
  input  logic                              halt,
  input  logic                              miso,
  input  logic                              tx_frame_start,
  input  logic                              tx_frame_done,
  input  adc_ctrl_pkg::frame_kind_e         tx_kind,
  output logic                              sample_valid,
  output logic [adc_ctrl_pkg::SAMPLE_W-1:0] sample,
  output adc_ctrl_pkg::frame_kind_e         sample_kind
);

  import adc_ctrl_pkg::*;

  logic                in_win;     // Inside the 16 capture cycles
  logic                cap;
  logic [SAMPLE_W-1:0] shreg;
  frame_kind_e         reply_kind; // Kind of the request being answered now

  assign cap = tx_frame_start | in_win;

  // Capture window follows the transmitter's frame
  always_ff @(posedge clk) begin
    if (!resetn || halt) in_win <= 1'b0;
    else if (tx_frame_done) in_win <= 1'b0;
    else if (tx_frame_start) in_win <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (cap) shreg <= {shreg[SAMPLE_W-2:0], miso}; // MSB arrives first
  end

  ////////////////////
  // Reply labelling, one frame behind the request

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      reply_kind   <= FK_NONE; // Nothing pending at the first frame
      sample_kind  <= FK_NONE;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= tx_frame_done && (reply_kind != FK_NONE); // Dummies dropped
      if (tx_frame_done) begin
        sample_kind <= reply_kind;
        reply_kind  <= tx_kind;  // This frame's request is answered next frame
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_frame_done) sample <= {shreg[SAMPLE_W-2:0], miso}; // Last bit taken directly
  end

endmodule

/* spi_frame_tx.sv */
`timescale 1ns/100ps

module spi_frame_tx (
  input  logic                          clk,
  input  logic                          resetn,
  input  logic                          halt,
  input  logic                          frame_start,
  input  logic [adc_ctrl_pkg::CH_W-1:0] frame_ch,
  input  adc_ctrl_pkg::frame_kind_e     frame_kind,
  output logic                          n_cs,
  output logic                          mosi,
  output logic                          frame_done,
  output logic                          tx_frame_start,
  output logic                          tx_frame_done,
  output adc_ctrl_pkg::frame_kind_e     tx_kind
);

  import adc_ctrl_pkg::*;

  logic [CS_CNT_W-1:0]   cs_cnt;  // n_cs high countdown
  logic [BIT_CNT_W-1:0]  bit_cnt; // Bits left in the frame, incl. the one on the wire
  logic [FRAME_BITS-1:0] shreg;   // MOSI request, MSB first
  logic                  n_cs_q;
  frame_kind_e           kind_q;

  ////////////////////
  // Chip select and bit counter

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      cs_cnt  <= '0;
      bit_cnt <= '0;
      n_cs_q  <= 1'b1;
      kind_q  <= FK_NONE;
    end else begin
      if (frame_start) begin
        cs_cnt <= CS_CNT_W'(CS_HIGH_CYCLES); // Hold n_cs high first
        kind_q <= frame_kind;
      end else if (cs_cnt != 0) begin
        cs_cnt <= cs_cnt - 1'b1;
      end
      if (cs_cnt == 1) begin
        n_cs_q  <= 1'b0;                     // High time over, open the frame
        bit_cnt <= BIT_CNT_W'(FRAME_BITS);
      end else if (bit_cnt != 0) begin
        bit_cnt <= bit_cnt - 1'b1;
        if (bit_cnt == 1) n_cs_q <= 1'b1;    // Close after the last bit
      end
    end
  end

  ////////////////////
  // MOSI shift register

  always_ff @(posedge clk) begin
    if (frame_start) begin
      shreg <= {OTF_REQ_PREFIX, frame_ch, {OTF_PAD_W{1'b0}}}; // On-the-fly request
    end else if (bit_cnt != 0) begin
      shreg <= {shreg[FRAME_BITS-2:0], 1'b0}; // Next bit after each rising edge
    end
  end

  assign n_cs = n_cs_q | halt;                // Forced high on error
  assign mosi = shreg[FRAME_BITS-1] & ~n_cs;  // Low outside frames
  assign frame_done = (bit_cnt == 1);         // Last bit on the wire

  // Receiver side. Start marks the first bit cycle, kind holds for the whole frame
  assign tx_frame_start = (bit_cnt == BIT_CNT_W'(FRAME_BITS));
  assign tx_frame_done  = frame_done;
  assign tx_kind        = kind_q;

endmodule

/* tb_adc_ctrl.sv */
`timescale 1ns/100ps

module tb_adc_ctrl;

  import adc_ctrl_pkg::*;

  localparam int N_SINGLE     = 8;    // Single reads in the chained test
  localparam int OBSERVE      = 40;   // Idle cycles watched after a halt
  localparam int RD_DELAY_MAX = 313;  // 250 plus up to 63
  localparam int NOP_MAX      = 41;
  localparam int TOTAL_FRAMES = (N_CH + 1) * 4 + 2 * N_SINGLE;
  localparam int WATCHDOG_CYCLES = 2 * 24 * TOTAL_FRAMES + 2 * RD_DELAY_MAX + 300
                                   + N_SINGLE * NOP_MAX + 20 + 7 * 17 + 8 * OBSERVE;

  logic             clk = 1'b0;
  logic             resetn;
  logic             cmd_buf_rd_en, cmd_buf_empty;
  logic [CMD_W-1:0] cmd_buf_word;
  logic             data_buf_wr_en, data_buf_full;
  logic [CMD_W-1:0] data_word;
  logic             bad_cmd, cmd_buf_underflow, data_buf_overflow, delay_too_short;
  logic             n_cs, mosi, miso;
  logic [3:0]       err_flags;  // bad, underflow, overflow, short

  logic [CMD_W-1:0] cmd_q[$];      // FWFT command buffer contents
  logic [CMD_W-1:0] exp_q[$];      // Expected data words, in order
  logic [CMD_W-1:0] test_cmds[$];  // Command list of the running test
  logic [CMD_W-1:0] exp_word;
  logic             pop_pending;
  int               words_seen;
  logic [31:0]      lcg_state = 32'd97796;

  assign err_flags = {bad_cmd, cmd_buf_underflow, data_buf_overflow, delay_too_short};

  always #2 clk = ~clk;  // 4 ns period

  adc_ctrl_top dut (
    .clk(clk), .resetn(resetn),
    .cmd_buf_rd_en(cmd_buf_rd_en), .cmd_buf_word(cmd_buf_word), .cmd_buf_empty(cmd_buf_empty),
    .data_buf_wr_en(data_buf_wr_en), .data_word(data_word), .data_buf_full(data_buf_full),
    .bad_cmd(bad_cmd), .cmd_buf_underflow(cmd_buf_underflow),
    .data_buf_overflow(data_buf_overflow), .delay_too_short(delay_too_short),
    .n_cs(n_cs), .mosi(mosi), .miso(miso)
  );

  adc_ads816x_model adc (.clk(clk), .resetn(resetn), .n_cs(n_cs), .mosi(mosi), .miso(miso));

  ////////////////////
  // Helpers

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {17'd0, lcg_state[30:16]};
  endfunction

  function automatic logic [CMD_W-1:0] make_rd(input int delay, input logic cont);
    return {OP_ADC_RD, 1'b0, cont, 2'b00, DELAY_W'(delay)};
  endfunction

  function automatic logic [CMD_W-1:0] make_rd_ch(input logic [CH_W-1:0] ch, input logic cont);
    return {OP_ADC_RD_CH, 1'b0, cont, 24'd0, ch};
  endfunction

  function automatic logic [CMD_W-1:0] make_no_op(input int delay, input logic cont);
    return {OP_NO_OP, 1'b0, cont, 2'b00, DELAY_W'(delay)};
  endfunction

  // ADC sample rule with the channel on top of the request count
  function automatic logic [SAMPLE_W-1:0] sample_value(input logic [CH_W-1:0] ch, input int n);
    return {ch, 13'(n % 8192)};
  endfunction

  // Reference model of the whole command list
  function automatic void compute_expected();
    logic [CH_W-1:0]     order [N_CH];
    logic [SAMPLE_W-1:0] lo, hi;
    logic [CMD_W-1:0]    c;
    int                  n;
    n = 0;
    for (int i = 0; i < N_CH; i++) order[i] = CH_W'(i);  // Identity after reset
    foreach (test_cmds[k]) begin
      c = test_cmds[k];
      case (c[OPCODE_HI:OPCODE_LO])
        OP_SET_ORD: for (int i = 0; i < N_CH; i++) order[i] = c[i*CH_W +: CH_W];
        OP_ADC_RD: begin
          for (int p = 0; p < N_CH / 2; p++) begin
            lo = sample_value(order[2*p], n + 2*p);
            hi = sample_value(order[2*p+1], n + 2*p + 1);
            exp_q.push_back({hi, lo});
          end
          n += N_CH + 1;  // Eight requests plus the dummy
        end
        OP_ADC_RD_CH: begin
          exp_q.push_back({16'd0, sample_value(c[CH_W-1:0], n)});
          n += 2;         // Request plus the dummy
        end
        default: ;
      endcase
    end
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s at %0t ns", msg, $time);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_values(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #0.5;
    resetn        = 1'b0;
    data_buf_full = 1'b0;
    cmd_q.delete();
    exp_q.delete();
    test_cmds.delete();
    words_seen = 0;
    repeat (16) @(posedge clk);
    #0.5;
    resetn = 1'b1;
  endtask

  task automatic push_all();
    @(posedge clk);
    #0.5;
    foreach (test_cmds[k]) cmd_q.push_back(test_cmds[k]);
  endtask

  task automatic wait_words(input int n);
    while (words_seen < n) @(negedge clk);
  endtask

  task automatic wait_flag(input int idx);
    while (!err_flags[idx]) @(negedge clk);
  endtask

  task automatic check_halted();
    repeat (OBSERVE) begin
      @(negedge clk);
      compare_values(32'(n_cs), 32'd1, "n_cs while halted");
    end
  endtask

  task automatic finish_clean_test(input string name);
    repeat (30) @(negedge clk);  // Catch stray writes
    compare_values(32'(err_flags), 32'd0, {name, " error flags"});
  endtask

  ////////////////////
  // Command buffer and data buffer models

  always @(negedge clk) pop_pending = cmd_buf_rd_en && !cmd_buf_empty;

  always @(posedge clk) begin
    #0.5;
    if (pop_pending && cmd_q.size() > 0) cmd_q.delete(0);  // FWFT pop
    cmd_buf_empty = (cmd_q.size() == 0);
    cmd_buf_word  = (cmd_q.size() > 0) ? cmd_q[0] : '0;
  end

  // Compare each data buffer write with the reference
  always @(negedge clk) begin
    if (resetn && data_buf_wr_en) begin
      if (exp_q.size() == 0) begin
        stop_with_failure("Data buffer written with no word expected");
      end else begin
        exp_word = exp_q.pop_front();
        compare_values(data_word, exp_word, "data word");
        words_seen++;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

  ////////////////////
  // Tests

  initial begin
    logic [CH_W-1:0] perm [N_CH];
    logic [CH_W-1:0] tmp;
    logic [23:0]     packed_ord;
    int              j;
    resetn        = 1'b0;
    cmd_buf_word  = '0;
    cmd_buf_empty = 1'b1;
    data_buf_full = 1'b0;
    pop_pending   = 1'b0;
    words_seen    = 0;

    // Default order read
    apply_reset();
    test_cmds.push_back(make_rd(250 + int'(next_random() % 64), 1'b0));
    compute_expected();
    push_all();
    wait_words(N_CH / 2);
    finish_clean_test("default order");

    // Random permutation, then a read
    apply_reset();
    for (int i = 0; i < N_CH; i++) perm[i] = CH_W'(i);
    for (int i = N_CH - 1; i > 0; i--) begin
      j       = int'(next_random() % (i + 1));  // Fisher-Yates shuffle
      tmp     = perm[i];
      perm[i] = perm[j];
      perm[j] = tmp;
    end
    for (int i = 0; i < N_CH; i++) packed_ord[i*CH_W +: CH_W] = perm[i];
    test_cmds.push_back({OP_SET_ORD, 5'd0, packed_ord});
    test_cmds.push_back(make_rd(250 + int'(next_random() % 64), 1'b0));
    compute_expected();
    push_all();
    wait_words(N_CH / 2);
    finish_clean_test("new order");

    // Chained single reads with delays in between
    apply_reset();
    for (int i = 0; i < N_SINGLE; i++) begin
      test_cmds.push_back(make_rd_ch(CH_W'(next_random()), 1'b1));
      test_cmds.push_back(make_no_op(10 + int'(next_random() % 32), i != N_SINGLE - 1));
    end
    compute_expected();
    push_all();
    wait_words(N_SINGLE);
    finish_clean_test("single reads");

    // Underflow, later commands ignored
    apply_reset();
    test_cmds.push_back(make_no_op(20, 1'b1));
    push_all();
    wait_flag(2);
    @(negedge clk);
    compare_values(32'(err_flags), 32'b0100, "underflow flags");
    test_cmds.delete();
    test_cmds.push_back(make_rd(300, 1'b0));
    push_all();
    check_halted();

    // Delay too short, then a bad opcode after reset
    apply_reset();
    test_cmds.push_back(make_rd(5, 1'b0));
    push_all();
    wait_flag(0);
    @(negedge clk);
    compare_values(32'(err_flags), 32'b0001, "short delay flags");
    check_halted();
    apply_reset();
    test_cmds.push_back({3'd6, 29'd0});
    push_all();
    wait_flag(3);
    @(negedge clk);
    compare_values(32'(err_flags), 32'b1000, "bad command flags");

    // Data buffer full during a read
    apply_reset();
    @(posedge clk);
    #0.5;
    data_buf_full = 1'b1;
    test_cmds.push_back(make_rd(300, 1'b0));
    push_all();
    wait_flag(1);
    @(negedge clk);
    compare_values(32'(err_flags), 32'b0010, "overflow flags");
    check_halted();

    $display("RESULT: PASS");
    $finish;
  end

endmodule
